/* logic/erx_consts.svh */
`ifndef ERX_CONSTS_SVH
`define ERX_CONSTS_SVH

// ############################
// link and packet widths
// ############################

`define ERX_WORD_W   16     // one sampled ddr word
`define ERX_SAMPLE_W 112    // seven words per transaction
`define ERX_PW       104    // emesh packet width

// ############################
// slow hand-off
// ############################

// cycles a valid pulse is held so one slow tick sees it
`define ERX_STRETCH  4

`endif

/* logic/erx_pkg.sv */
`include "erx_consts.svh"

package erx_pkg;

   // raw link word as delivered by the samplers
   typedef logic [`ERX_WORD_W-1:0]   erx_word_t;

   // full transaction before reordering
   typedef logic [`ERX_SAMPLE_W-1:0] erx_sample_t;

   // dstaddr / data / srcaddr all share this
   typedef logic [31:0]              erx_addr_t;

   typedef logic [3:0]               erx_ctrl_t;   // ctrlmode nibble

   // transfer size of the access
   typedef enum logic [1:0]
   {
      DM_BYTE   = 2'b00,   // 8 bit
      DM_HALF   = 2'b01,   // 16 bit
      DM_WORD   = 2'b10,   // 32 bit
      DM_DOUBLE = 2'b11    // 64 bit
   } erx_datamode_t;

endpackage

/* logic/erx_frame_assembler.sv */
`timescale 1ns/1ps
`include "erx_consts.svh"

module erx_frame_assembler
(
   input  logic                 rx_lclk,
   input  logic                 reset,
   input  erx_pkg::erx_word_t   rx_word,    // sampled link word
   input  logic                 rx_frame,   // high for whole transaction
   output erx_pkg::erx_sample_t sample,     // assembled 112 bit sample
   output logic                 word_done,  // cycle after slot 6 stored
   output logic                 frame_q     // frame lined up with word_done
);

   import erx_pkg::*;

   localparam int NSLOT = `ERX_SAMPLE_W / `ERX_WORD_W;   // 7 words
   localparam int HDR_WORDS = 3;                         // reused in a burst

   localparam logic [NSLOT-1:0] PTR_FIRST = 1;                 // word 0
   localparam logic [NSLOT-1:0] PTR_BODY  = 1 << HDR_WORDS;    // word 3

   logic [NSLOT-1:0] word_ptr;   // one-hot write slot

   // ############################
   // write pointer
   // ############################

   always_ff @(posedge rx_lclk)
   begin
      if (reset || !rx_frame)
         word_ptr <= PTR_FIRST;                       // idle or new frame
      else if (word_ptr[NSLOT-1])
         word_ptr <= PTR_BODY;                        // expect burst body next
      else
         word_ptr <= {word_ptr[NSLOT-2:0], 1'b0};     // next slot
   end

   // ############################
   // sample register
   // ############################

   // payload only
   always_ff @(posedge rx_lclk)
   begin
      for (int i = 0; i < NSLOT; i++)
      begin
         if (rx_frame && word_ptr[i])
            sample[i*`ERX_WORD_W +: `ERX_WORD_W] <= rx_word;
      end
   end

   // header slots 0..2 survive the wrap so burst packets share them

   // ############################
   // completion strobe
   // ############################

   always_ff @(posedge rx_lclk)
   begin
      if (reset)
      begin
         word_done <= 1'b0;
         frame_q   <= 1'b0;
      end
      else
      begin
         word_done <= rx_frame & word_ptr[NSLOT-1];   // last slot just taken
         frame_q   <= rx_frame;
      end
   end

endmodule

/* logic/erx_packet_decoder.sv */
`timescale 1ns/1ps
`include "erx_consts.svh"

module erx_packet_decoder
(
   input  logic                   rx_lclk,
   input  logic                   reset,
   input  erx_pkg::erx_sample_t   sample,
   input  logic                   word_done,
   input  logic                   frame_q,
   output logic                   pkt_valid,      // one cycle after word_done
   output logic                   pkt_burst,      // follows another in same frame
   output logic                   pkt_access,
   output logic                   pkt_write,
   output erx_pkg::erx_datamode_t pkt_datamode,
   output erx_pkg::erx_ctrl_t     pkt_ctrlmode,
   output erx_pkg::erx_addr_t     pkt_dstaddr,
   output erx_pkg::erx_addr_t     pkt_data,
   output erx_pkg::erx_addr_t     pkt_srcaddr
);

   import erx_pkg::*;

   logic [`ERX_PW-1:0] packet;   // emesh order
   logic               burst_seen;

   // ############################
   // byte shuffle
   // ############################

   // ddr sampling puts bytes in link order so rebuild emesh layout
   assign packet[0]      = sample[40];         // access
   assign packet[1]      = sample[41];         // write
   assign packet[3:2]    = sample[43:42];      // datamode
   assign packet[7:4]    = sample[15:12];      // ctrlmode
   assign packet[39:8]   = {sample[11:8],      // dstaddr msb nibble
                            sample[23:16],
                            sample[31:24],
                            sample[39:32],
                            sample[47:44]};    // dstaddr lsb nibble
   assign packet[71:40]  = {sample[55:48], sample[63:56],
                            sample[71:64], sample[79:72]};
   assign packet[103:72] = {sample[87:80], sample[95:88],
                            sample[103:96], sample[111:104]};

   // ############################
   // valid and burst tracking
   // ############################

   always_ff @(posedge rx_lclk)
   begin
      if (reset)
      begin
         pkt_valid  <= 1'b0;
         burst_seen <= 1'b0;
      end
      else
      begin
         pkt_valid <= word_done;
         if (word_done && frame_q)
            burst_seen <= 1'b1;                // later packets of this frame
         else if (!frame_q)
            burst_seen <= 1'b0;                // gap ends the burst
      end
   end

   // field hold until next word_done
   always_ff @(posedge rx_lclk)
   begin
      if (word_done)
      begin
         pkt_burst    <= burst_seen;           // value before this packet
         pkt_access   <= packet[0];
         pkt_write    <= packet[1];
         pkt_datamode <= erx_datamode_t'(packet[3:2]);
         pkt_ctrlmode <= packet[7:4];
         pkt_dstaddr  <= packet[39:8];
         pkt_data     <= packet[71:40];
         pkt_srcaddr  <= packet[103:72];
      end
   end

endmodule

/* logic/erx_slow_handoff.sv */
`timescale 1ns/1ps
`include "erx_consts.svh"

module erx_slow_handoff
(
   input  logic                   rx_lclk,
   input  logic                   reset,
   input  logic                   pkt_valid,
   input  logic                   pkt_burst,
   input  logic                   pkt_access,
   input  logic                   pkt_write,
   input  erx_pkg::erx_datamode_t pkt_datamode,
   input  erx_pkg::erx_ctrl_t     pkt_ctrlmode,
   input  erx_pkg::erx_addr_t     pkt_dstaddr,
   input  erx_pkg::erx_addr_t     pkt_data,
   input  erx_pkg::erx_addr_t     pkt_srcaddr,
   output logic                   rx_tick,        // one cycle in four
   output logic                   rx_access,      // qualify with rx_tick
   output logic                   rx_burst,
   output logic                   rx_pkt_access,
   output logic                   rx_write,
   output erx_pkg::erx_datamode_t rx_datamode,
   output erx_pkg::erx_ctrl_t     rx_ctrlmode,
   output erx_pkg::erx_addr_t     rx_dstaddr,
   output erx_pkg::erx_addr_t     rx_data,
   output erx_pkg::erx_addr_t     rx_srcaddr
);

   import erx_pkg::*;

   localparam int SW = $clog2(`ERX_STRETCH);

   logic [1:0]    phase;     // slow clock phase
   logic [SW-1:0] stretch;   // cycles left after the pulse
   logic          valid_wide;

   // ############################
   // slow tick
   // ############################

   always_ff @(posedge rx_lclk)
   begin
      if (reset)
         phase <= 2'd0;
      else
         phase <= phase + 2'd1;   // free running
   end

   assign rx_tick = (phase == 2'd3);

   // pulse plus ERX_STRETCH-1 cycles so exactly one tick lands inside
   always_ff @(posedge rx_lclk)
   begin
      if (reset)
         stretch <= '0;
      else if (pkt_valid)
         stretch <= SW'(`ERX_STRETCH - 1);   // reload
      else if (stretch != '0)
         stretch <= stretch - 1'b1;
   end

   assign valid_wide = pkt_valid | (stretch != '0);

   // ############################
   // slow capture
   // ############################

   always_ff @(posedge rx_lclk)
   begin
      if (reset)
      begin
         rx_access <= 1'b0;
         rx_burst  <= 1'b0;
      end
      else if (rx_tick)
      begin
         rx_access <= valid_wide;          // drops on an empty tick
         if (valid_wide)
            rx_burst <= pkt_burst;
      end
   end

   always_ff @(posedge rx_lclk)
   begin
      if (rx_tick && valid_wide)
      begin
         rx_pkt_access <= pkt_access;
         rx_write      <= pkt_write;
         rx_datamode   <= pkt_datamode;
         rx_ctrlmode   <= pkt_ctrlmode;
         rx_dstaddr    <= pkt_dstaddr;
         rx_data       <= pkt_data;
         rx_srcaddr    <= pkt_srcaddr;
      end
   end

endmodule

/* logic/erx_rx.sv */
`timescale 1ns/1ps

module erx_rx
(
   input  logic                   rx_lclk,
   input  logic                   reset,
   input  erx_pkg::erx_word_t     rx_word,
   input  logic                   rx_frame,
   output logic                   rx_tick,
   output logic                   rx_access,
   output logic                   rx_burst,
   output logic                   rx_pkt_access,
   output logic                   rx_write,
   output erx_pkg::erx_datamode_t rx_datamode,
   output erx_pkg::erx_ctrl_t     rx_ctrlmode,
   output erx_pkg::erx_addr_t     rx_dstaddr,
   output erx_pkg::erx_addr_t     rx_data,
   output erx_pkg::erx_addr_t     rx_srcaddr
);

   import erx_pkg::*;

   // ############################
   // stage wires
   // ############################

   erx_sample_t   sample;
   logic          word_done;
   logic          frame_q;

   logic          pkt_valid;
   logic          pkt_burst;
   logic          pkt_access;
   logic          pkt_write;
   erx_datamode_t pkt_datamode;
   erx_ctrl_t     pkt_ctrlmode;
   erx_addr_t     pkt_dstaddr;
   erx_addr_t     pkt_data;
   erx_addr_t     pkt_srcaddr;

   // words to 112 bit sample
   erx_frame_assembler u_assembler
   (
      .rx_lclk   (rx_lclk),
      .reset     (reset),
      .rx_word   (rx_word),
      .rx_frame  (rx_frame),
      .sample    (sample),
      .word_done (word_done),
      .frame_q   (frame_q)
   );

   // sample to packet fields
   erx_packet_decoder u_decoder
   (
      .rx_lclk      (rx_lclk),
      .reset        (reset),
      .sample       (sample),
      .word_done    (word_done),
      .frame_q      (frame_q),
      .pkt_valid    (pkt_valid),
      .pkt_burst    (pkt_burst),
      .pkt_access   (pkt_access),
      .pkt_write    (pkt_write),
      .pkt_datamode (pkt_datamode),
      .pkt_ctrlmode (pkt_ctrlmode),
      .pkt_dstaddr  (pkt_dstaddr),
      .pkt_data     (pkt_data),
      .pkt_srcaddr  (pkt_srcaddr)
   );

   // fast pulse to slow phase
   erx_slow_handoff u_handoff
   (
      .rx_lclk       (rx_lclk),
      .reset         (reset),
      .pkt_valid     (pkt_valid),
      .pkt_burst     (pkt_burst),
      .pkt_access    (pkt_access),
      .pkt_write     (pkt_write),
      .pkt_datamode  (pkt_datamode),
      .pkt_ctrlmode  (pkt_ctrlmode),
      .pkt_dstaddr   (pkt_dstaddr),
      .pkt_data      (pkt_data),
      .pkt_srcaddr   (pkt_srcaddr),
      .rx_tick       (rx_tick),
      .rx_access     (rx_access),
      .rx_burst      (rx_burst),
      .rx_pkt_access (rx_pkt_access),
      .rx_write      (rx_write),
      .rx_datamode   (rx_datamode),
      .rx_ctrlmode   (rx_ctrlmode),
      .rx_dstaddr    (rx_dstaddr),
      .rx_data       (rx_data),
      .rx_srcaddr    (rx_srcaddr)
   );

endmodule

/* test/erx_props.sv */
`timescale 1ns/1ps
`include "erx_consts.svh"

module erx_props
(
   input logic                                      rx_lclk,
   input logic                                      reset,
   input logic [`ERX_SAMPLE_W/`ERX_WORD_W-1:0]      word_ptr,    // assembler slot select
   input logic                                      pkt_valid,
   input logic                                      rx_tick,
   input logic                                      rx_access,
   input logic                                      rx_burst,
   input logic                                      rx_pkt_access,
   input logic                                      rx_write,
   input erx_pkg::erx_datamode_t                    rx_datamode,
   input erx_pkg::erx_ctrl_t                        rx_ctrlmode,
   input erx_pkg::erx_addr_t                        rx_dstaddr,
   input erx_pkg::erx_addr_t                        rx_data,
   input erx_pkg::erx_addr_t                        rx_srcaddr
);

   logic [2:0] valid_hist;     // last three pkt_valid values
   logic       fields_known;   // slow fields written at least once

   always_ff @(posedge rx_lclk)
   begin
      if (reset)
      begin
         valid_hist   <= '0;
         fields_known <= 1'b0;
      end
      else
      begin
         valid_hist <= {valid_hist[1:0], pkt_valid};
         if (rx_access)
            fields_known <= 1'b1;
      end
   end

   // ############################
   // properties
   // ############################

   a_ptr_onehot: assert property (@(posedge rx_lclk) disable iff (reset)
      $onehot(word_ptr))
      else $error("assembler word pointer not one-hot: %b", word_ptr);

   // packets never closer than four cycles
   a_valid_spacing: assert property (@(posedge rx_lclk) disable iff (reset)
      pkt_valid |-> (valid_hist == 3'b000))
      else $error("pkt_valid fired twice within four cycles");

   a_access_stable: assert property (@(posedge rx_lclk) disable iff (reset)
      !$past(rx_tick) |-> $stable({rx_access, rx_burst}))
      else $error("rx_access or rx_burst changed away from a tick");

   a_fields_stable: assert property (@(posedge rx_lclk) disable iff (reset)
      (fields_known && !$past(rx_tick)) |->
         $stable({rx_pkt_access, rx_write, rx_datamode, rx_ctrlmode,
                  rx_dstaddr, rx_data, rx_srcaddr}))
      else $error("slow packet fields changed away from a tick");

endmodule

bind erx_rx erx_props u_props
(
   .rx_lclk       (rx_lclk),
   .reset         (reset),
   .word_ptr      (u_assembler.word_ptr),
   .pkt_valid     (pkt_valid),
   .rx_tick       (rx_tick),
   .rx_access     (rx_access),
   .rx_burst      (rx_burst),
   .rx_pkt_access (rx_pkt_access),
   .rx_write      (rx_write),
   .rx_datamode   (rx_datamode),
   .rx_ctrlmode   (rx_ctrlmode),
   .rx_dstaddr    (rx_dstaddr),
   .rx_data       (rx_data),
   .rx_srcaddr    (rx_srcaddr)
);

/* test/erx_tb.sv */
`timescale 1ns/1ps
`include "erx_consts.svh"

module erx_tb;

   import erx_pkg::*;

   localparam int NUM_FRAMES = 60;
   localparam int MAX_AGE    = 14;   // last word to tick sample, worst case plus margin

   // expected packet as the model sees it
   typedef struct packed
   {
      logic          access;
      logic          write;
      erx_datamode_t mode;
      erx_ctrl_t     ctrl;
      erx_addr_t     dst;
      erx_addr_t     data;
      erx_addr_t     src;
      logic          burst;
      logic [31:0]   stamp;   // cycle of the last word
   } exp_pkt_t;

   logic          rx_lclk;
   logic          reset;
   erx_word_t     rx_word;
   logic          rx_frame;
   logic          rx_tick;
   logic          rx_access;
   logic          rx_burst;
   logic          rx_pkt_access;
   logic          rx_write;
   erx_datamode_t rx_datamode;
   erx_ctrl_t     rx_ctrlmode;
   erx_addr_t     rx_dstaddr;
   erx_addr_t     rx_data;
   erx_addr_t     rx_srcaddr;

   exp_pkt_t      exp_q[$];
   int            burst_len[NUM_FRAMES];
   int            gap_len[NUM_FRAMES];
   int            total_words = 0;
   bit            plan_ready  = 1'b0;       // watchdog starts once lengths known
   int unsigned   cycle       = 0;
   int unsigned   live_cycles = 0;          // cycles since reset released
   int            mismatches  = 0;
   int            other_errs  = 0;
   int            sent_pkts   = 0;
   int            seen_pkts   = 0;

   erx_rx DUT
   (
      .rx_lclk       (rx_lclk),
      .reset         (reset),
      .rx_word       (rx_word),
      .rx_frame      (rx_frame),
      .rx_tick       (rx_tick),
      .rx_access     (rx_access),
      .rx_burst      (rx_burst),
      .rx_pkt_access (rx_pkt_access),
      .rx_write      (rx_write),
      .rx_datamode   (rx_datamode),
      .rx_ctrlmode   (rx_ctrlmode),
      .rx_dstaddr    (rx_dstaddr),
      .rx_data       (rx_data),
      .rx_srcaddr    (rx_srcaddr)
   );

   initial rx_lclk = 1'b0;
   always #5 rx_lclk = ~rx_lclk;   // 100 MHz

   always @(posedge rx_lclk) cycle <= cycle + 1;

   // slow period restarts with reset, tick due every fourth cycle
   always @(posedge rx_lclk)
   begin
      if (reset)
         live_cycles <= 0;
      else
         live_cycles <= live_cycles + 1;
   end

   // ############################
   // compare tasks
   // ############################

   task automatic check_addr(input string name, input erx_addr_t got, input erx_addr_t exp);
      if (got !== exp)
      begin
         mismatches++;
         $display("MISMATCH %0t %s got %h exp %h", $time, name, got, exp);
      end
   endtask

   task automatic check_mode(input string name, input erx_datamode_t got,
                             input erx_datamode_t exp);
      if (got !== exp)
      begin
         mismatches++;
         $display("MISMATCH %0t %s got %s exp %s", $time, name, got.name(), exp.name());
      end
   endtask

   task automatic check_ctrl(input string name, input erx_ctrl_t got, input erx_ctrl_t exp);
      if (got !== exp)
      begin
         mismatches++;
         $display("MISMATCH %0t %s got %h exp %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         mismatches++;
         $display("MISMATCH %0t %s got %b exp %b", $time, name, got, exp);
      end
   endtask

   // ############################
   // link encoding
   // ############################

   // inverse of the byte shuffle, pad fills the unused low byte
   function automatic erx_sample_t encode_sample(input exp_pkt_t p, input logic [7:0] pad);
      erx_sample_t s;
      s           = '0;
      s[7:0]      = pad;
      s[11:8]     = p.dst[31:28];   // dstaddr top nibble
      s[15:12]    = p.ctrl;
      s[23:16]    = p.dst[27:20];
      s[31:24]    = p.dst[19:12];
      s[39:32]    = p.dst[11:4];
      s[40]       = p.access;
      s[41]       = p.write;
      s[43:42]    = p.mode;
      s[47:44]    = p.dst[3:0];
      s[55:48]    = p.data[31:24];  // data msb first
      s[63:56]    = p.data[23:16];
      s[71:64]    = p.data[15:8];
      s[79:72]    = p.data[7:0];
      s[87:80]    = p.src[31:24];
      s[95:88]    = p.src[23:16];
      s[103:96]   = p.src[15:8];
      s[111:104]  = p.src[7:0];
      return s;
   endfunction

   task automatic drive_word(input erx_word_t w);
      @(posedge rx_lclk);
      #1;
      rx_word  = w;
      rx_frame = 1'b1;
   endtask

   task automatic drive_idle(input int n);
      repeat (n)
      begin
         @(posedge rx_lclk);
         #1;
         rx_frame = 1'b0;
         rx_word  = erx_word_t'($urandom);   // junk on an idle link
      end
   endtask

   // one frame, header once, then four body words per extra packet
   task automatic send_frame(input int len);
      exp_pkt_t    p;
      erx_sample_t s;
      int          first;
      for (int k = 0; k < len; k++)
      begin
         if (k == 0)
         begin
            p.access = 1'($urandom);
            p.write  = 1'($urandom);
            p.mode   = erx_datamode_t'($urandom_range(0, 3));
            p.ctrl   = erx_ctrl_t'($urandom);
            p.dst    = $urandom;
         end
         p.data  = $urandom;
         p.src   = $urandom;
         p.burst = (k != 0);
         s       = encode_sample(p, 8'($urandom));
         first   = (k == 0) ? 0 : 3;
         for (int w = first; w < 7; w++)
            drive_word(s[w*`ERX_WORD_W +: `ERX_WORD_W]);
         p.stamp = cycle;
         exp_q.push_back(p);
         sent_pkts++;
      end
   endtask

   // ############################
   // output model
   // ############################

   task automatic compare_output();
      exp_pkt_t e;
      if (exp_q.size() == 0)
      begin
         other_errs++;
         $display("ERROR %0t: rx_access on a tick with no packet pending", $time);
      end
      else
      begin
         e = exp_q.pop_front();
         check_bit("rx_pkt_access", rx_pkt_access, e.access);
         check_bit("rx_write", rx_write, e.write);
         check_bit("rx_burst", rx_burst, e.burst);
         check_mode("rx_datamode", rx_datamode, e.mode);
         check_ctrl("rx_ctrlmode", rx_ctrlmode, e.ctrl);
         check_addr("rx_dstaddr", rx_dstaddr, e.dst);
         check_addr("rx_data", rx_data, e.data);
         check_addr("rx_srcaddr", rx_srcaddr, e.src);
         seen_pkts++;
      end
   endtask

   // sample mid cycle, consumer view is rx_access qualified by rx_tick
   always @(negedge rx_lclk)
   begin
      if (!reset)
      begin
         check_bit("rx_tick", rx_tick, (live_cycles % 4) == 3);   // phase 3 only
         if (rx_tick)
         begin
            if (rx_access === 1'b1)
               compare_output();
            else if (exp_q.size() != 0 && (cycle - exp_q[0].stamp) > MAX_AGE)
            begin
               other_errs++;
               $display("ERROR %0t: packet with data %h never appeared on the output",
                        $time, exp_q[0].data);
               void'(exp_q.pop_front());   // drop it so later packets still line up
            end
         end
      end
   end

   // ############################
   // watchdog
   // ############################

   initial
   begin
      wait (plan_ready);
      repeat (40 * total_words + 200) @(posedge rx_lclk);
      $display("ERROR %0t: run did not finish within the watchdog limit", $time);
      $display("Regression failed");
      $finish;
   end

   // ############################
   // main sequence
   // ############################

   initial
   begin
      void'($urandom(32'h2d05_f098));
      reset    = 1'b1;
      rx_frame = 1'b0;
      rx_word  = '0;

      for (int f = 0; f < NUM_FRAMES; f++)
      begin
         burst_len[f] = $urandom_range(1, 3);
         gap_len[f]   = $urandom_range(1, 5);
         total_words += 7 + 4 * (burst_len[f] - 1);
      end
      plan_ready = 1'b1;

      repeat (10) @(posedge rx_lclk);
      #1 reset = 1'b0;

      // quiet link after reset
      repeat (12)
      begin
         @(negedge rx_lclk);
         check_bit("rx_access", rx_access, 1'b0);
         check_bit("rx_burst", rx_burst, 1'b0);
      end

      for (int f = 0; f < NUM_FRAMES; f++)
      begin
         send_frame(burst_len[f]);
         drive_idle(gap_len[f]);
      end

      while (exp_q.size() != 0)
         @(posedge rx_lclk);
      repeat (16) @(posedge rx_lclk);   // catch stray outputs

      if (exp_q.size() != 0 || seen_pkts != sent_pkts)
      begin
         other_errs++;
         $display("ERROR: %0d packets sent but %0d received, %0d left in queue",
                  sent_pkts, seen_pkts, exp_q.size());
      end

      $display("summary: %0d sent, %0d received, %0d mismatches, %0d other errors",
               sent_pkts, seen_pkts, mismatches, other_errs);
      if (mismatches == 0 && other_errs == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

/* compile.f */
+incdir+logic
logic/erx_pkg.sv
logic/erx_frame_assembler.sv
logic/erx_packet_decoder.sv
logic/erx_slow_handoff.sv
logic/erx_rx.sv
test/erx_props.sv
test/erx_tb.sv

/* Makefile */
# Verilator flow for the erx receive pipeline
TOP := erx_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP) -o $(TOP)

# pass only if the pass line shows up in the simulation output
run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
